// File: verilog/kbd_pkg.sv
package kbd_pkg;

	// one scan code, set 1 or set 2
	typedef logic [7:0] scan_code_t;

	// set 2 break prefix, passes the translator unchanged
	localparam scan_code_t break_prefix = 8'hF0;

	// set 1 marks a key release with the top bit
	localparam int unsigned break_bit = 7;

	// keyboard answer after a reset request on pb6
	localparam scan_code_t self_test_ok = 8'hAA;

	// start, 8 data, parity, stop
	localparam int unsigned frame_bits = 11;

	// flops per keyboard line before use in clk domain
	localparam int unsigned sync_stages = 2;

endpackage

// File: verilog/ps2_receiver.sv
module ps2_receiver (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                kbd_clk,
	input  logic                kbd_data,
	output kbd_pkg::scan_code_t raw_code,
	output logic                code_valid
);

	localparam int unsigned top = kbd_pkg::sync_stages - 1;
	localparam int unsigned code_bits = $bits(kbd_pkg::scan_code_t);

	logic [top:0] clk_sync;
	logic [top:0] data_sync;
	logic clk_prev;                              // last synchronized kbd_clk
	logic clk_fall;
	logic last_edge;
	logic [$clog2(kbd_pkg::frame_bits)-1:0] bit_cnt;   // falling edges seen in frame
	kbd_pkg::scan_code_t shift_q;

	// both lines idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync <= '1;
			data_sync <= '1;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[top-1:0], kbd_clk};
			data_sync <= {data_sync[top-1:0], kbd_data};
			clk_prev <= clk_sync[top];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[top];
	assign last_edge = clk_fall && (bit_cnt == kbd_pkg::frame_bits - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= last_edge;
			if (last_edge)
				bit_cnt <= '0;          // stop bit ends the frame
			else if (clk_fall)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// data bits ride on edges 2 to 9 lsb first
	always_ff @(posedge clk) begin
		if (clk_fall && bit_cnt != 0 && bit_cnt <= code_bits)
			shift_q <= {data_sync[top], shift_q[code_bits-1:1]};
	end

	// hold the finished code while the next frame shifts in
	always_ff @(posedge clk) begin
		if (last_edge)
			raw_code <= shift_q;
	end

endmodule

// File: verilog/scan_translate.sv
module scan_translate (
	input  kbd_pkg::scan_code_t raw_code,
	output kbd_pkg::scan_code_t xt_code
);

	always_comb begin
		case (raw_code)
			8'h00: xt_code = 8'hFF;    // keyboard error / overrun
			8'h01: xt_code = 8'h43;
			8'h02: xt_code = 8'h41;
			8'h03: xt_code = 8'h3F;
			8'h04: xt_code = 8'h3D;
			8'h05: xt_code = 8'h3B;
			8'h06: xt_code = 8'h3C;
			8'h07: xt_code = 8'h58;
			8'h08: xt_code = 8'h64;
			8'h09: xt_code = 8'h44;
			8'h0A: xt_code = 8'h42;
			8'h0B: xt_code = 8'h40;
			8'h0C: xt_code = 8'h3E;
			8'h0D: xt_code = 8'h0F;
			8'h0E: xt_code = 8'h29;
			8'h0F: xt_code = 8'h59;
			8'h10: xt_code = 8'h65;
			8'h11: xt_code = 8'h38;
			8'h12: xt_code = 8'h2A;
			8'h13: xt_code = 8'h70;
			8'h14: xt_code = 8'h1D;
			8'h15: xt_code = 8'h10;
			8'h16: xt_code = 8'h02;
			8'h17: xt_code = 8'h5A;
			8'h18: xt_code = 8'h66;
			8'h19: xt_code = 8'h71;
			8'h1A: xt_code = 8'h2C;
			8'h1B: xt_code = 8'h1F;
			8'h1C: xt_code = 8'h1E;    // 'a'
			8'h1D: xt_code = 8'h11;
			8'h1E: xt_code = 8'h03;
			8'h1F: xt_code = 8'h5B;
			8'h20: xt_code = 8'h67;
			8'h21: xt_code = 8'h2E;
			8'h22: xt_code = 8'h2D;
			8'h23: xt_code = 8'h20;
			8'h24: xt_code = 8'h12;
			8'h25: xt_code = 8'h05;
			8'h26: xt_code = 8'h04;
			8'h27: xt_code = 8'h5C;
			8'h28: xt_code = 8'h68;
			8'h29: xt_code = 8'h39;
			8'h2A: xt_code = 8'h2F;
			8'h2B: xt_code = 8'h21;
			8'h2C: xt_code = 8'h14;
			8'h2D: xt_code = 8'h13;
			8'h2E: xt_code = 8'h06;
			8'h2F: xt_code = 8'h5D;
			8'h30: xt_code = 8'h69;
			8'h31: xt_code = 8'h31;
			8'h32: xt_code = 8'h30;
			8'h33: xt_code = 8'h23;
			8'h34: xt_code = 8'h22;
			8'h35: xt_code = 8'h15;
			8'h36: xt_code = 8'h07;
			8'h37: xt_code = 8'h5E;
			8'h38: xt_code = 8'h6A;
			8'h39: xt_code = 8'h72;
			8'h3A: xt_code = 8'h32;
			8'h3B: xt_code = 8'h24;
			8'h3C: xt_code = 8'h16;
			8'h3D: xt_code = 8'h08;
			8'h3E: xt_code = 8'h09;
			8'h3F: xt_code = 8'h5F;
			8'h40: xt_code = 8'h6B;
			8'h41: xt_code = 8'h33;
			8'h42: xt_code = 8'h25;
			8'h43: xt_code = 8'h17;
			8'h44: xt_code = 8'h18;
			8'h45: xt_code = 8'h0B;
			8'h46: xt_code = 8'h0A;
			8'h47: xt_code = 8'h60;
			8'h48: xt_code = 8'h6C;
			8'h49: xt_code = 8'h34;
			8'h4A: xt_code = 8'h35;
			8'h4B: xt_code = 8'h26;
			8'h4C: xt_code = 8'h27;
			8'h4D: xt_code = 8'h19;
			8'h4E: xt_code = 8'h0C;
			8'h4F: xt_code = 8'h61;
			8'h50: xt_code = 8'h6D;
			8'h51: xt_code = 8'h73;
			8'h52: xt_code = 8'h28;
			8'h53: xt_code = 8'h74;
			8'h54: xt_code = 8'h1A;
			8'h55: xt_code = 8'h0D;
			8'h56: xt_code = 8'h62;
			8'h57: xt_code = 8'h6E;
			8'h58: xt_code = 8'h3A;
			8'h59: xt_code = 8'h36;
			8'h5A: xt_code = 8'h1C;    // enter
			8'h5B: xt_code = 8'h1B;
			8'h5C: xt_code = 8'h75;
			8'h5D: xt_code = 8'h2B;
			8'h5E: xt_code = 8'h63;
			8'h5F: xt_code = 8'h76;
			8'h60: xt_code = 8'h55;
			8'h61: xt_code = 8'h56;
			8'h62: xt_code = 8'h77;
			8'h63: xt_code = 8'h78;
			8'h64: xt_code = 8'h79;
			8'h65: xt_code = 8'h7A;
			8'h66: xt_code = 8'h0E;
			8'h67: xt_code = 8'h7B;
			8'h68: xt_code = 8'h7C;
			8'h69: xt_code = 8'h4F;
			8'h6A: xt_code = 8'h7D;
			8'h6B: xt_code = 8'h4B;
			8'h6C: xt_code = 8'h47;
			8'h6D: xt_code = 8'h7E;
			8'h6E: xt_code = 8'h7F;
			8'h6F: xt_code = 8'h6F;
			8'h70: xt_code = 8'h52;
			8'h71: xt_code = 8'h53;
			8'h72: xt_code = 8'h50;
			8'h73: xt_code = 8'h4C;
			8'h74: xt_code = 8'h4D;
			8'h75: xt_code = 8'h48;
			8'h76: xt_code = 8'h01;    // esc
			8'h77: xt_code = 8'h45;
			8'h78: xt_code = 8'h57;
			8'h79: xt_code = 8'h4E;
			8'h7A: xt_code = 8'h51;
			8'h7B: xt_code = 8'h4A;
			8'h7C: xt_code = 8'h37;
			8'h7D: xt_code = 8'h49;
			8'h7E: xt_code = 8'h46;
			8'h7F: xt_code = 8'h54;
			// f7 and alt-sysrq sit above 0x80 in set 2
			8'h83: xt_code = 8'h41;
			8'h84: xt_code = 8'h54;
			default: xt_code = raw_code;    // identity, incl. break prefix
		endcase
	end

endmodule

// File: verilog/xt_port_ctrl.sv
module xt_port_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                code_valid,
	input  logic                pb6,
	input  logic                pb7,
	input  kbd_pkg::scan_code_t xt_code,
	output kbd_pkg::scan_code_t pa,
	output logic                irq1
);

	typedef enum logic [2:0] {
		idle,
		make_hold,
		wait_clear,
		break_wait,
		break_hold,
		reset_low,
		reset_high
	} port_state_e;

	port_state_e state;
	kbd_pkg::scan_code_t brk_code;

	// set 1 release code is the make code with the top bit set
	always_comb begin
		brk_code = xt_code;
		brk_code[kbd_pkg::break_bit] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			pa <= '0;
			irq1 <= 1'b0;
		end else begin
			irq1 <= 1'b0;      // only the hold states raise it
			if (!pb6) begin
				// host resets the keyboard, drop whatever is in flight
				state <= reset_low;
				if (state == idle)
					pa <= '0;
			end else begin
				case (state)
					idle: begin
						if (code_valid) begin
							if (xt_code == kbd_pkg::break_prefix) begin
								state <= break_wait;
							end else begin
								pa <= xt_code;
								state <= make_hold;
							end
						end
					end
					make_hold, break_hold: begin
						if (pb7) begin
							pa <= '0;      // port reads empty until next code
							state <= wait_clear;
						end else begin
							irq1 <= 1'b1;
						end
					end
					wait_clear: begin
						if (!pb7)
							state <= idle;
					end
					break_wait: begin
						// a repeated prefix keeps waiting for the key
						if (code_valid && xt_code != kbd_pkg::break_prefix) begin
							pa <= brk_code;
							state <= break_hold;
						end
					end
					reset_low: state <= reset_high;    // pb6 released
					reset_high: begin
						if (!pb7) begin
							pa <= kbd_pkg::self_test_ok;
							state <= make_hold;
						end
					end
					default: state <= idle;
				endcase
			end
		end
	end

endmodule

// File: verilog/xt_keyboard_if.sv
module xt_keyboard_if (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                kbd_clk,
	input  logic                kbd_data,
	input  logic                pb6,       // keyboard reset request, low
	input  logic                pb7,       // host acknowledge
	output kbd_pkg::scan_code_t pa,
	output logic                irq1
);

	kbd_pkg::scan_code_t raw_code;   // set 2, from the wire
	kbd_pkg::scan_code_t xt_code;    // set 1
	logic code_valid;

	ps2_receiver rx_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.kbd_clk    (kbd_clk),
		.kbd_data   (kbd_data),
		.raw_code   (raw_code),
		.code_valid (code_valid)
	);

	scan_translate xlat_i (
		.raw_code (raw_code),
		.xt_code  (xt_code)
	);

	xt_port_ctrl port_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.code_valid (code_valid),
		.pb6        (pb6),
		.pb7        (pb7),
		.xt_code    (xt_code),
		.pa         (pa),
		.irq1       (irq1)
	);

endmodule

// File: tests/xt_port_props.sv
module xt_port_props (
	input logic                clk,
	input logic                rst_n,
	input logic                pb7,
	input kbd_pkg::scan_code_t pa,
	input logic                irq1
);

	// host reads pa while irq1 is up
	pa_stable: assert property (@(posedge clk) disable iff (!rst_n)
		irq1 |=> (!irq1 || $stable(pa)))
		else $error("pa changed while irq1 was high");

	ack_drops_irq: assert property (@(posedge clk) disable iff (!rst_n)
		(irq1 && pb7) |=> !irq1)
		else $error("irq1 stayed high after pb7 acknowledge");

	// no request may leak out of reset
	reset_quiet: assert property (@(posedge clk) !rst_n |-> !irq1)
		else $error("irq1 high during reset");

endmodule

bind xt_keyboard_if xt_port_props props_i (
	.clk   (clk),
	.rst_n (rst_n),
	.pb7   (pb7),
	.pa    (pa),
	.irq1  (irq1)
);

// File: tests/tb_xt_keyboard_if.sv
module tb_xt_keyboard_if;

	localparam int exchanges = 48;                    // 8 directed, 40 random
	localparam int irq_limit = 4 * 11 * 16;           // up to three frames plus slack
	localparam int watchdog_clocks = exchanges * 4 * 11 * 16 + 200 + 16;

	logic clk = 1'b0;
	logic rst_n, kbd_clk, kbd_data, pb6, pb7;
	logic [7:0] pa;
	logic irq1;
	logic [15:0] lfsr_q = 16'd62274;
	logic [7:0] expect_q[$];
	int pending = 0;
	int checks = 0;
	int errors = 0;

	xt_keyboard_if dut_i (
		.clk(clk), .rst_n(rst_n), .kbd_clk(kbd_clk), .kbd_data(kbd_data),
		.pb6(pb6), .pb7(pb7), .pa(pa), .irq1(irq1)
	);

	always #20 clk = ~clk;

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw(input int n, output int unsigned val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			val = {val[30:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [7:0] code_at(input int idx);
		case (idx)
			0: return 8'h00;
			1: return 8'h1C;
			2: return 8'h76;
			3: return 8'h83;
			4: return 8'h84;
			5: return 8'h9A;
			6: return 8'h5A;
			7: return 8'h16;
			8: return 8'h29;
			9: return 8'h66;
			10: return 8'h7E;
			default: return 8'h12;
		endcase
	endfunction

	// set 1 value for each code of the list
	function automatic logic [7:0] xt_expect(input logic [7:0] code, input logic brk);
		logic [7:0] x;
		case (code)
			8'h00: x = 8'hFF;
			8'h1C: x = 8'h1E;
			8'h76: x = 8'h01;
			8'h83: x = 8'h41;
			8'h84: x = 8'h54;
			8'h5A: x = 8'h1C;
			8'h16: x = 8'h02;
			8'h29: x = 8'h39;
			8'h66: x = 8'h0E;
			8'h7E: x = 8'h46;
			8'h12: x = 8'h2A;
			default: x = code;      // 0x80 and up pass through
		endcase
		if (brk)
			x[7] = 1'b1;
		return x;
	endfunction

	// start, 8 data lsb first, odd parity, stop
	task automatic send_frame(input logic [7:0] code);
		logic [10:0] bits;
		bits = {1'b1, ~^code, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			repeat (4) @(posedge clk);
			kbd_data <= bits[i];      // change while kbd_clk high
			repeat (4) @(posedge clk);
			kbd_clk <= 1'b0;
			repeat (8) @(posedge clk);
			kbd_clk <= 1'b1;
		end
	endtask

	task automatic send_key(input logic [7:0] code, input logic brk, input logic dbl);
		expect_q.push_back(xt_expect(code, brk));
		pending++;
		if (brk)
			send_frame(8'hF0);
		if (dbl)
			send_frame(8'hF0);
		send_frame(code);
		wait (pending == 0);
	endtask

	initial begin : host
		logic [7:0] want;
		logic seen;
		forever begin
			wait (pending != 0);
			want = expect_q[0];
			seen = 1'b0;
			for (int i = 0; i < irq_limit && !seen; i++) begin
				@(negedge clk);
				seen = irq1;
			end
			checks++;
			assert (seen) else begin
				$display("irq1 never rose for the code expected as %h", want);
				errors++;
			end
			if (seen) begin
				checks++;
				assert (pa == want) else begin
					$display("FAIL pa expected %h got %h", want, pa);
					errors++;
				end
				@(posedge clk);
				pb7 <= 1'b1;
				for (int i = 0; i < 8 && irq1; i++)
					@(negedge clk);
				checks += 2;
				assert (!irq1) else begin
					$display("irq1 stayed high after the acknowledge on pb7");
					errors++;
				end
				assert (pa == 8'h00) else begin     // empty until next code
					$display("FAIL pa expected %h got %h", 8'h00, pa);
					errors++;
				end
				@(posedge clk);
				pb7 <= 1'b0;
			end
			void'(expect_q.pop_front());
			pending--;
		end
	end

	initial begin : stimulus
		int unsigned idx, brk, dbl, gap;
		rst_n = 1'b1;
		kbd_clk = 1'b1;
		kbd_data = 1'b1;
		pb6 = 1'b1;
		pb7 = 1'b0;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(negedge clk);
		checks += 2;
		assert (pa == 8'h00) else begin
			$display("FAIL pa expected %h got %h", 8'h00, pa);
			errors++;
		end
		assert (!irq1) else begin
			$display("FAIL irq1 expected %h got %h", 1'b0, irq1);
			errors++;
		end
		send_key(8'h1C, 1'b0, 1'b0);
		send_key(8'h1C, 1'b1, 1'b0);
		send_key(8'h76, 1'b1, 1'b1);   // doubled prefix
		// self-test after a pb6 pulse
		expect_q.push_back(8'hAA);
		pending++;
		@(posedge clk);
		pb6 <= 1'b0;
		repeat (4) @(posedge clk);
		pb6 <= 1'b1;
		wait (pending == 0);
		send_key(8'h00, 1'b0, 1'b0);
		send_key(8'h83, 1'b0, 1'b0);
		send_key(8'h84, 1'b0, 1'b0);
		send_key(8'h9A, 1'b0, 1'b0);
		repeat (40) begin
			draw(4, idx);
			draw(1, brk);
			draw(1, dbl);
			draw(4, gap);
			send_key(code_at(idx % 12), brk[0], brk[0] & dbl[0]);
			repeat (gap + 2) @(posedge clk);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin : watchdog
		repeat (watchdog_clocks) @(posedge clk);
		$display("run exceeded its time limit, %0d checks, %0d errors", checks, errors);
		$display("tests failed");
		$finish;
	end

endmodule

// File: vlog.f
verilog/kbd_pkg.sv
verilog/ps2_receiver.sv
verilog/scan_translate.sv
verilog/xt_port_ctrl.sv
verilog/xt_keyboard_if.sv
tests/xt_port_props.sv
tests/tb_xt_keyboard_if.sv
